// ==== sim.f ====
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_ctrl_fsm.sv
verilog/spi_sclk_timer.sv
verilog/spi_shift_unit.sv
verilog/spi_master.sv
sim/spi_slave_model.sv
sim/tb_spi_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_spi_master \
  -Mdir "$build_dir" \
  -o tb_spi_master

"./$build_dir/tb_spi_master" 2>&1 | tee "$log_file"

if grep -q 'All tests passed!' "$log_file"
then
  echo "simulation passed"
else
  echo "simulation failed, see $log_file"
  exit 1
fi

// ==== sim/tb_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module tb_spi_master;

  import spi_pkg::*;

  localparam int num_random  = 200;
  localparam int num_cmds    = 8 + 16 + 6 + num_random;
  // read frame with setup, hold and return to idle
  localparam int frame_max   = (`SPI_CMD_BITS + `SPI_READ_BITS + 2) * 2 * `SPI_HALF_PERIOD + 4;
  localparam int cycle_limit = num_cmds * frame_max * 2;

  logic      clk;
  logic      rst_n;
  spi_cmd_t  cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      sclk;
  logic      cs_n;
  logic      mosi;
  logic      miso;
  logic      read_vld;
  spi_byte_t read_data;

  spi_byte_t   shadow [0:7];
  spi_byte_t   exp_mem [0:255];
  spi_byte_t   exp_byte;
  int          wr_idx = 0;
  int          rd_idx = 0;
  int          sent_cnt = 0;
  int          accept_cnt = 0;
  int          frame_cnt = 0;
  int          cycle_cnt = 0;
  logic        cs_n_q = 1'b1;
  logic [31:0] rnd = 32'hd108_1555;

  spi_master i_spi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model i_slave_model (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected read byte from all writes seen so far
  function automatic spi_byte_t ref_read(input spi_addr_t addr);
    return shadow[addr];
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // hand a command over and wait for it to be taken
  task automatic issue_cmd(input spi_cmd_t cmd, input logic keep_vld);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    do
      @(negedge clk);
    while (!cmd_rdy);
    @(posedge clk);
    sent_cnt++;
    if (cmd[`SPI_WRITE_FLAG_BIT])
      shadow[cmd[`SPI_ADDR_LSB +: `SPI_ADDR_BITS]] = cmd[`SPI_READ_BITS-1:0];
    else
    begin
      exp_mem[wr_idx] = ref_read(cmd[`SPI_ADDR_LSB +: `SPI_ADDR_BITS]);
      wr_idx++;
    end
    #1;
    // frame opens right after acceptance with the write flag on mosi
    check_eq("cs_n after accept", 32'(cs_n), 32'd0);
    check_eq("mosi after accept", 32'(mosi), 32'(cmd[`SPI_WRITE_FLAG_BIT]));
    if (!keep_vld)
      cmd_vld = 1'b0;
  endtask

  // handshake, frame and read strobe monitor
  always @(negedge clk)
  begin
    cs_n_q <= cs_n;
    if (rst_n && cmd_vld && cmd_rdy)
      accept_cnt++;
    if (rst_n && cs_n && !cs_n_q)
      frame_cnt++;
    if (rst_n && read_vld)
    begin
      if (rd_idx >= wr_idx)
      begin
        $display("read_vld pulsed while no read frame was in flight");
        $display("Test failures found");
        $fatal(1, "unexpected read_vld");
      end
      else
      begin
        exp_byte = exp_mem[rd_idx];
        rd_idx++;
        check_eq("read_data", 32'(read_data), 32'(exp_byte));
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
      shadow[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_eq("cmd_rdy after reset", 32'(cmd_rdy), 32'd1);
    check_eq("cs_n after reset", 32'(cs_n), 32'd1);
    check_eq("sclk after reset", 32'(sclk), 32'd0);
    @(posedge clk);
    #1;

    // nothing written yet
    for (int a = 0; a < 8; a++)
      issue_cmd({1'b0, 3'(a), 8'h00}, 1'b0);

    for (int a = 0; a < 8; a++)
    begin
      rnd = lcg_next(rnd);
      issue_cmd({1'b1, 3'(a), rnd[23:16]}, 1'b0);
      issue_cmd({1'b0, 3'(a), rnd[31:24]}, 1'b0);
    end

    // cmd_vld stays high across frames
    for (int k = 0; k < 6; k++)
    begin
      rnd = lcg_next(rnd);
      issue_cmd(rnd[27:16], 1'b1);
    end
    cmd_vld = 1'b0;

    for (int k = 0; k < num_random; k++)
    begin
      rnd = lcg_next(rnd);
      issue_cmd(rnd[27:16], 1'b0);
    end

    do
      @(negedge clk);
    while (!cmd_rdy);
    repeat (2) @(posedge clk);
    #1;
    check_eq("accepted commands", accept_cnt, sent_cnt);
    check_eq("completed frames", frame_cnt, accept_cnt);
    check_eq("read_vld pulses", rd_idx, wr_idx);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/spi_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_slave_model (
  input  wire  rst_n,
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso
);

  logic [`SPI_CMD_BITS-1:0]  cmd_sr;
  logic [`SPI_CMD_BITS-1:0]  cmd_next;
  logic [`SPI_READ_BITS-1:0] regs [0:7];
  logic [`SPI_READ_BITS-1:0] tx_byte;
  logic [4:0]                bit_cnt;

  assign cmd_next = {cmd_sr[`SPI_CMD_BITS-2:0], mosi};
  assign miso     = tx_byte[`SPI_READ_BITS-1];

  // command bits sampled on rising sclk
  always @(posedge sclk or negedge rst_n or posedge cs_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      cmd_sr  <= '0;
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (cs_n)
      bit_cnt <= '0;
    else
    begin
      if (bit_cnt < 5'(`SPI_CMD_BITS))
        cmd_sr <= cmd_next;
      if ((bit_cnt == 5'(`SPI_CMD_BITS - 1)) && cmd_next[`SPI_WRITE_FLAG_BIT])
        regs[cmd_next[`SPI_ADDR_LSB +: `SPI_ADDR_BITS]] <= cmd_next[`SPI_READ_BITS-1:0];
      if (bit_cnt != 5'd31)
        bit_cnt <= bit_cnt + 5'd1;
    end
  end

  // read byte goes out msb first on falling sclk
  always @(negedge sclk or negedge rst_n)
  begin
    if (!rst_n)
      tx_byte <= '0;
    else if (!cs_n)
    begin
      if ((bit_cnt == 5'(`SPI_CMD_BITS)) && !cmd_sr[`SPI_WRITE_FLAG_BIT])
        tx_byte <= regs[cmd_sr[`SPI_ADDR_LSB +: `SPI_ADDR_BITS]];
      else
        tx_byte <= {tx_byte[`SPI_READ_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire spi_pkg::spi_cmd_t cmd_in,
  input  wire                    cmd_vld,
  output logic                   cmd_rdy,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  input  wire                    miso,
  output logic                   read_vld,
  output spi_pkg::spi_byte_t     read_data
);

  import spi_pkg::*;

  logic        cmd_wr;
  logic        run;
  logic        sclk_en;
  logic        cnt_clr;
  logic        load;
  logic        capture_en;
  logic        half_tick;
  logic        sclk_rise;
  logic        sclk_fall;
  spi_bitcnt_t bit_cnt;

  assign cmd_wr = cmd_is_write(cmd_in);

  spi_ctrl_fsm i_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_wr     (cmd_wr),
    .half_tick  (half_tick),
    .sclk_fall  (sclk_fall),
    .bit_cnt    (bit_cnt),
    .cmd_rdy    (cmd_rdy),
    .cs_n       (cs_n),
    .run        (run),
    .sclk_en    (sclk_en),
    .cnt_clr    (cnt_clr),
    .load       (load),
    .capture_en (capture_en),
    .read_vld   (read_vld)
  );

  spi_sclk_timer i_sclk_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .sclk_en   (sclk_en),
    .cnt_clr   (cnt_clr),
    .half_tick (half_tick),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .bit_cnt   (bit_cnt)
  );

  spi_shift_unit i_shift_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (load),
    .cmd_in     (cmd_in),
    .sclk_rise  (sclk_rise),
    .sclk_fall  (sclk_fall),
    .capture_en (capture_en),
    .miso       (miso),
    .mosi       (mosi),
    .read_data  (read_data)
  );

endmodule

`default_nettype wire

// ==== verilog/spi_shift_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_shift_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   load,
  input  wire spi_pkg::spi_cmd_t cmd_in,
  input  wire                   sclk_rise,
  input  wire                   sclk_fall,
  input  wire                   capture_en,
  input  wire                   miso,
  output logic                  mosi,
  output spi_pkg::spi_byte_t    read_data
);

  import spi_pkg::*;

  spi_cmd_t  tx_shift;
  spi_byte_t rx_shift;
  logic      capture_en_q;

  // msb first
  assign mosi = tx_shift[`SPI_CMD_BITS-1];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_shift <= '0;
    else if (load)
      tx_shift <= cmd_in;
    else if (sclk_fall)
      tx_shift <= {tx_shift[`SPI_CMD_BITS-2:0], 1'b0};
  end

  // sample on rising edge, read phase only
  always_ff @(posedge clk)
  begin
    if (capture_en && sclk_rise)
      rx_shift <= {rx_shift[`SPI_READ_BITS-2:0], miso};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      capture_en_q <= 1'b0;
    else
      capture_en_q <= capture_en;
  end

  // publish the byte once the read phase closes, so read_data
  // stays put while the next frame shifts in
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (capture_en_q && !capture_en)
      read_data <= rx_shift;
  end

  a_load_no_fall: assert property (@(posedge clk) disable iff (!rst_n)
    !(load && sclk_fall));

endmodule

`default_nettype wire

// ==== verilog/spi_sclk_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_sclk_timer (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   run,
  input  wire                   sclk_en,
  input  wire                   cnt_clr,
  output logic                  half_tick,
  output logic                  sclk,
  output logic                  sclk_rise,
  output logic                  sclk_fall,
  output spi_pkg::spi_bitcnt_t  bit_cnt
);

  import spi_pkg::*;

  logic [3:0] div_cnt;
  logic       sclk_q;

  assign half_tick = run && (div_cnt == 4'(`SPI_HALF_PERIOD - 1));

  // strobes mark the cycle in which sclk_q toggles
  assign sclk_rise = half_tick && sclk_en && !sclk_q;
  assign sclk_fall = half_tick && sclk_en && sclk_q;
  assign sclk      = sclk_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (!run || half_tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sclk_q <= 1'b0;
    else if (!sclk_en)
      sclk_q <= 1'b0;
    else if (half_tick)
      sclk_q <= ~sclk_q;
  end

  // falling edges seen in the current phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!run || cnt_clr)
      bit_cnt <= '0;
    else if (sclk_fall && (bit_cnt != spi_bitcnt_t'(`SPI_BITCNT_MAX)))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // sclk_en must only drop after a falling edge
  a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    !sclk_en |-> !sclk_q);

endmodule

`default_nettype wire

// ==== verilog/spi_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_consts.svh"

module spi_ctrl_fsm (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  cmd_vld,
  input  wire                  cmd_wr,
  input  wire                  half_tick,
  input  wire                  sclk_fall,
  input  wire spi_pkg::spi_bitcnt_t bit_cnt,
  output logic                 cmd_rdy,
  output logic                 cs_n,
  output logic                 run,
  output logic                 sclk_en,
  output logic                 cnt_clr,
  output logic                 load,
  output logic                 capture_en,
  output logic                 read_vld
);

  import spi_pkg::*;

  spi_state_t  state;
  spi_state_t  state_nxt;
  logic        wr_flag;
  spi_bitcnt_t hold_cnt;
  logic        accept;
  logic        cmd_end;
  logic        read_end;
  logic        hold_end;

  assign accept = (state == ST_IDLE) && cmd_vld;

  // phase ends on the falling edge that completes the last bit
  assign cmd_end = (state == ST_SHIFT_CMD) && sclk_fall &&
                   (bit_cnt == spi_bitcnt_t'(`SPI_CMD_BITS - 1));
  assign read_end = (state == ST_SHIFT_READ) && sclk_fall &&
                    (bit_cnt == spi_bitcnt_t'(`SPI_READ_BITS - 1));
  assign hold_end = (state == ST_HOLD) && half_tick &&
                    (hold_cnt == spi_bitcnt_t'(`SPI_CS_HOLD - 1));

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (accept)
          state_nxt = ST_SETUP;
      end
      ST_SETUP:
      begin
        // mosi already shows bit 11, give it one half period
        if (half_tick)
          state_nxt = ST_SHIFT_CMD;
      end
      ST_SHIFT_CMD:
      begin
        if (cmd_end)
          state_nxt = wr_flag ? ST_HOLD : ST_SHIFT_READ;
      end
      ST_SHIFT_READ:
      begin
        if (read_end)
          state_nxt = ST_HOLD;
      end
      ST_HOLD:
      begin
        if (hold_end)
          state_nxt = ST_DONE;
      end
      ST_DONE:
      begin
        state_nxt = ST_IDLE;
      end
      default:
      begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // write flag latched once per frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_flag <= 1'b0;
    else if (accept)
      wr_flag <= cmd_wr;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      hold_cnt <= '0;
    else if (state != ST_HOLD)
      hold_cnt <= '0;
    else if (half_tick)
      hold_cnt <= hold_cnt + 1'b1;
  end

  // chip select and read strobe, both registered
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs_n     <= 1'b1;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= hold_end && !wr_flag;
      if (accept)
        cs_n <= 1'b0;
      else if (hold_end)
        cs_n <= 1'b1;
    end
  end

  assign cmd_rdy    = (state == ST_IDLE);
  assign run        = (state inside {ST_SETUP, ST_SHIFT_CMD, ST_SHIFT_READ, ST_HOLD});
  assign sclk_en    = (state inside {ST_SHIFT_CMD, ST_SHIFT_READ});
  assign cnt_clr    = cmd_end && !wr_flag;
  assign load       = accept;
  assign capture_en = (state == ST_SHIFT_READ);

  a_idle_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> cs_n);

  a_read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld);

endmodule

`default_nettype wire

// ==== verilog/spi_pkg.sv ====
`default_nettype none

`include "spi_consts.svh"

package spi_pkg;

  typedef logic [`SPI_CMD_BITS-1:0]  spi_cmd_t;
  typedef logic [`SPI_ADDR_BITS-1:0] spi_addr_t;
  typedef logic [`SPI_READ_BITS-1:0] spi_byte_t;
  typedef logic [3:0]                spi_bitcnt_t;

  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_SETUP      = 3'd1,
    ST_SHIFT_CMD  = 3'd2,
    ST_SHIFT_READ = 3'd3,
    ST_HOLD       = 3'd4,
    ST_DONE       = 3'd5
  } spi_state_t;

  // write flag of a command word
  function automatic logic cmd_is_write(input spi_cmd_t cmd);
    return cmd[`SPI_WRITE_FLAG_BIT];
  endfunction

endpackage

`default_nettype wire

// ==== verilog/spi_consts.svh ====
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// frame layout
`define SPI_CMD_BITS       12
`define SPI_READ_BITS      8
`define SPI_WRITE_FLAG_BIT 11
`define SPI_ADDR_LSB       8
`define SPI_ADDR_BITS      3

// clk cycles per sclk half period
`define SPI_HALF_PERIOD    5

// half ticks with cs_n still low after the last sclk edge
`define SPI_CS_HOLD        1

// bit counter saturation value
`define SPI_BITCNT_MAX     15

`endif
